// File: files.f
src/lsu_isa_pkg.sv
src/lsu_core_pkg.sv
src/ls_request_gen.sv
src/ls_queue.sv
src/ls_mem_access.sv
src/load_data_align.sv
src/load_store_unit.sv
testbench/tb_clock_gen.sv
testbench/load_store_unit_props.sv
testbench/load_store_unit_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the load/store unit simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module load_store_unit_tb \
    -f files.f \
    -o sim_load_store_unit

./obj_dir/sim_load_store_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi

echo "Simulation finished without failures"
exit 0

// File: src/load_data_align.sv
// Load result byte and halfword selection with sign or zero extension
`default_nettype none

module load_data_align (
    input  logic                          rd_valid,
    input  logic [lsu_core_pkg::XLEN-1:0] rd_word,
    input  lsu_core_pkg::ls_req_t         rd_attr,
    output logic                          wb_valid,
    output lsu_core_pkg::ls_result_t      wb
);
    import lsu_isa_pkg::*;
    import lsu_core_pkg::*;

    logic [1:0]      byte_off;
    logic [7:0]      sel_byte;
    logic [15:0]     sel_half;
    logic [XLEN-1:0] load_data;

    assign byte_off = rd_attr.addr[1:0];
    assign sel_byte = rd_word[8*byte_off +: 8];
    // Halfwords are aligned, so bit 1 picks the half
    assign sel_half = byte_off[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        case (rd_attr.fn3)
            LS_B:    load_data = {{(XLEN-8){sel_byte[7]}}, sel_byte};
            L_BU:    load_data = {{(XLEN-8){1'b0}}, sel_byte};
            LS_H:    load_data = {{(XLEN-16){sel_half[15]}}, sel_half};
            L_HU:    load_data = {{(XLEN-16){1'b0}}, sel_half};
            default: load_data = rd_word;
        endcase
    end

    assign wb_valid = rd_valid;
    assign wb       = '{id: rd_attr.id, data: load_data};

endmodule

`default_nettype wire

// File: src/load_store_unit.sv
// Load/store unit top level with request generator, queue, memory access and load formatting
`default_nettype none

module load_store_unit #(
    parameter int QUEUE_DEPTH = 4,
    parameter int MEM_WORDS   = 256
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     issue_valid,
    input  lsu_core_pkg::ls_issue_t  issue,
    output logic                     wb_valid,
    output lsu_core_pkg::ls_result_t wb,
    output logic                     exc_valid,
    output lsu_core_pkg::ls_exc_t    exc,
    output logic                     idle
);
    import lsu_core_pkg::*;

    logic            req_valid;
    ls_req_t         req;
    logic            head_valid;
    ls_req_t         head;
    logic            pop;
    logic            queue_empty;
    logic            rd_valid;
    logic [XLEN-1:0] rd_word;
    ls_req_t         rd_attr;

    ls_request_gen u_ls_request_gen (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .req_valid   (req_valid),
        .req         (req),
        .exc_valid   (exc_valid),
        .exc         (exc)
    );

    ls_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_ls_queue (
        .clk        (clk),
        .rst        (rst),
        .push       (req_valid),
        .push_data  (req),
        .pop        (pop),
        .head_valid (head_valid),
        .head       (head),
        .empty      (queue_empty)
    );

    ls_mem_access #(.MEM_WORDS(MEM_WORDS)) u_ls_mem_access (
        .clk        (clk),
        .rst        (rst),
        .head_valid (head_valid),
        .head       (head),
        .pop        (pop),
        .rd_valid   (rd_valid),
        .rd_word    (rd_word),
        .rd_attr    (rd_attr)
    );

    load_data_align u_load_data_align (
        .rd_valid (rd_valid),
        .rd_word  (rd_word),
        .rd_attr  (rd_attr),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    // Nothing queued, nothing about to be pushed, no read outstanding
    assign idle = queue_empty & ~req_valid & ~rd_valid;

endmodule

`default_nettype wire

// File: src/ls_mem_access.sv
// Request consumer with byte-enabled local data RAM and registered load read
`default_nettype none

module ls_mem_access #(
    parameter int MEM_WORDS = 256
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            head_valid,
    input  lsu_core_pkg::ls_req_t           head,
    output logic                            pop,
    output logic                            rd_valid,
    output logic [lsu_core_pkg::XLEN-1:0]   rd_word,
    output lsu_core_pkg::ls_req_t           rd_attr
);
    import lsu_core_pkg::*;

    localparam int IDX_W  = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int NBYTES = XLEN / 8;

    logic [XLEN-1:0]  ram [MEM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic             do_store;
    logic             do_load;

    //////////////////////////////
    // Request control

    // Consumer never stalls, every visible entry leaves next edge
    assign pop = head_valid;

    assign do_store = head_valid & head.is_store;
    assign do_load  = head_valid & ~head.is_store;

    // Word index wraps around the RAM size
    assign word_idx = IDX_W'(head.addr[XLEN-1:2] % MEM_WORDS);

    //////////////////////////////
    // RAM

    always_ff @(posedge clk) begin
        if (do_store) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (head.be[b])
                    ram[word_idx][8*b +: 8] <= head.data[8*b +: 8];
            end
        end
    end

    // Registered read, attributes follow the data
    always_ff @(posedge clk) begin
        if (do_load) begin
            rd_word <= ram[word_idx];
            rd_attr <= head;
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            rd_valid <= 1'b0;
        else
            rd_valid <= do_load;
    end

endmodule

`default_nettype wire

// File: src/ls_queue.sv
// Circular request FIFO between address generation and memory access
`default_nettype none

module ls_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  push,
    input  lsu_core_pkg::ls_req_t push_data,
    input  logic                  pop,
    output logic                  head_valid,
    output lsu_core_pkg::ls_req_t head,
    output logic                  empty
);
    import lsu_core_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    ls_req_t          entries [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    // Wraps at QUEUE_DEPTH, also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        next_ptr = (ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full       = (count == CNT_W'(QUEUE_DEPTH));
    assign empty      = (count == '0);
    assign head_valid = ~empty;
    assign head       = entries[rd_ptr];

    assign do_push = push & ~full;
    assign do_pop  = pop & head_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            entries[wr_ptr] <= push_data;
    end

endmodule

`default_nettype wire

// File: src/ls_request_gen.sv
// Load/store request generator with address calculation, byte enables and misalignment check
`default_nettype none

module ls_request_gen (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   issue_valid,
    input  lsu_core_pkg::ls_issue_t issue,
    output logic                   req_valid,
    output lsu_core_pkg::ls_req_t  req,
    output logic                   exc_valid,
    output lsu_core_pkg::ls_exc_t  exc
);
    import lsu_isa_pkg::*;
    import lsu_core_pkg::*;

    ls_instr_u       instr_view;
    logic [2:0]      fn3;
    logic            is_load;
    logic            is_store;
    logic [11:0]     offset;
    logic [XLEN-1:0] addr;
    logic            misaligned;
    logic [3:0]      be;
    logic [XLEN-1:0] store_data;

    //////////////////////////////
    // Decode
    assign instr_view = issue.instr;
    assign fn3        = instr_view.i.fn3;
    assign is_load    = (instr_view.i.opcode == LOAD_OPCODE);
    assign is_store   = (instr_view.s.opcode == STORE_OPCODE);

    // Stores split the offset, loads keep it in one field
    assign offset = is_store ? {instr_view.s.imm_hi, instr_view.s.imm_lo} : instr_view.i.imm;
    assign addr   = issue.rs1 + {{(XLEN-12){offset[11]}}, offset};

    //////////////////////////////
    // Alignment
    always_comb begin
        case (fn3)
            LS_H, L_HU: misaligned = addr[0];
            LS_W:       misaligned = |addr[1:0];
            default:    misaligned = 1'b0;
        endcase
    end

    // Byte enables and store data replicated into every lane
    always_comb begin
        be         = '0;
        store_data = issue.rs2;
        case (fn3[1:0])
            LS_B[1:0]: begin
                be[addr[1:0]] = 1'b1;
                store_data    = {4{issue.rs2[7:0]}};
            end
            LS_H[1:0]: begin
                be         = addr[1] ? 4'b1100 : 4'b0011;
                store_data = {2{issue.rs2[15:0]}};
            end
            default: be = 4'b1111;
        endcase
    end

    //////////////////////////////
    // Output registers
    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
            exc_valid <= 1'b0;
        end else begin
            req_valid <= issue_valid & (is_load | is_store) & ~misaligned;
            exc_valid <= issue_valid & (is_load | is_store) & misaligned;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            req <= '{
                addr:     addr,
                fn3:      fn3,
                be:       be,
                data:     store_data,
                is_store: is_store,
                id:       issue.id
            };
            exc <= '{
                code: is_store ? STORE_ADDR_MISALIGNED : LOAD_ADDR_MISALIGNED,
                tval: addr,
                id:   issue.id
            };
        end
    end

endmodule

`default_nettype wire

// File: src/lsu_core_pkg.sv
// Unit widths, issue packet, queue entry, load result and exception report structs
`default_nettype none

package lsu_core_pkg;

    localparam int XLEN = 32;
    localparam int ID_W = 4;

    typedef logic [ID_W-1:0] id_t;

    typedef struct packed {
        logic [31:0]     instr;
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        id_t             id;
    } ls_issue_t;

    // One aligned request in the queue
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [2:0]      fn3;
        logic [3:0]      be;
        logic [XLEN-1:0] data;
        logic            is_store;
        id_t             id;
    } ls_req_t;

    typedef struct packed {
        id_t             id;
        logic [XLEN-1:0] data;
    } ls_result_t;

    typedef struct packed {
        lsu_isa_pkg::ls_exc_code_t code;
        logic [XLEN-1:0]           tval;
        id_t                       id;
    } ls_exc_t;

endpackage

`default_nettype wire

// File: src/lsu_isa_pkg.sv
// RISC-V load/store opcodes, fn3 codes, exception codes and instruction format views
`default_nettype none

package lsu_isa_pkg;

    // Major opcodes
    localparam logic [6:0] LOAD_OPCODE  = 7'b0000011;
    localparam logic [6:0] STORE_OPCODE = 7'b0100011;

    // Access width and signedness
    localparam logic [2:0] LS_B = 3'b000;
    localparam logic [2:0] LS_H = 3'b001;
    localparam logic [2:0] LS_W = 3'b010;
    localparam logic [2:0] L_BU = 3'b100;
    localparam logic [2:0] L_HU = 3'b101;

    typedef enum logic [3:0] {
        LOAD_ADDR_MISALIGNED  = 4'd4,
        STORE_ADDR_MISALIGNED = 4'd6
    } ls_exc_code_t;

    // Load view
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  fn3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // Store view, offset split around rs2/rs1
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] fn3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    typedef union packed {
        i_type_t i;
        s_type_t s;
    } ls_instr_u;

endpackage

`default_nettype wire

// File: testbench/load_store_unit_props.sv
// Concurrent assertions on writeback, exception and queue behavior of the load/store unit
`default_nettype none

module load_store_unit_props (
    input logic                     clk,
    input logic                     rst,
    input logic                     issue_valid,
    input lsu_core_pkg::ls_issue_t  issue,
    input logic                     wb_valid,
    input lsu_core_pkg::ls_result_t wb,
    input logic                     exc_valid,
    input lsu_core_pkg::ls_exc_t    exc,
    input logic                     push,
    input logic                     queue_full
);
    timeunit 1ns;
    timeprecision 100ps;

    import lsu_isa_pkg::*;
    import lsu_core_pkg::*;

    ls_instr_u   view;
    logic [31:0] ld_addr;
    logic        ld_aligned;

    assign view    = issue.instr;
    assign ld_addr = issue.rs1 + {{20{view.i.imm[11]}}, view.i.imm};
    assign ld_aligned = (view.i.fn3 == LS_W) ? (ld_addr[1:0] == 2'b00) :
                        (view.i.fn3 == LS_H || view.i.fn3 == L_HU) ? ~ld_addr[0] : 1'b1;

    wb_exc_distinct: assert property (@(posedge clk) disable iff (rst)
        (wb_valid && exc_valid) |-> (wb.id != exc.id))
        else $error("writeback and exception in one cycle for the same id");

    load_latency: assert property (@(posedge clk) disable iff (rst)
        (issue_valid && view.i.opcode == LOAD_OPCODE && ld_aligned) |-> ##3 wb_valid)
        else $error("aligned load without writeback three cycles later");

    no_overflow: assert property (@(posedge clk) disable iff (rst)
        !(push && queue_full))
        else $error("push into a full request queue");

endmodule

bind load_store_unit load_store_unit_props u_props (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue       (issue),
    .wb_valid    (wb_valid),
    .wb          (wb),
    .exc_valid   (exc_valid),
    .exc         (exc),
    .push        (req_valid),
    .queue_full  (u_ls_queue.full)
);

`default_nettype wire

// File: testbench/load_store_unit_tb.sv
// Load/store unit testbench with stimulus table, reference byte memory, checks and watchdog
`default_nettype none

module load_store_unit_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import lsu_isa_pkg::*;
    import lsu_core_pkg::*;

    typedef struct packed {
        logic        st;
        logic [2:0]  fn3;
        logic [11:0] off;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [3:0]  id;
    } row_t;

    typedef struct packed {
        logic [31:0] due;
        logic [3:0]  id;
        logic [31:0] data;
        logic [3:0]  code;
    } expect_t;

    logic       clk;
    logic       rst;
    logic       issue_valid;
    ls_issue_t  issue;
    logic       wb_valid;
    ls_result_t wb;
    logic       exc_valid;
    ls_exc_t    exc;
    logic       idle;

    row_t        rows[$];
    expect_t     wb_exp[$];
    expect_t     exc_exp[$];
    logic [7:0]  ref_mem [1024];
    logic [31:0] cycle;
    logic [3:0]  next_id;
    integer      seed;
    integer      error_count;

    tb_clock_gen u_clock (.clk(clk), .rst(rst));

    load_store_unit #(.QUEUE_DEPTH(4), .MEM_WORDS(256)) u_load_store_unit (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue       (issue),
        .wb_valid    (wb_valid),
        .wb          (wb),
        .exc_valid   (exc_valid),
        .exc         (exc),
        .idle        (idle)
    );

    always @(posedge clk) begin
        if (rst)
            cycle <= '0;
        else
            cycle <= cycle + 1;
    end

    task automatic check(input string what, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            error_count = error_count + 1;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, actual, expected);
            $display("Checks failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic add_row(input logic st, input logic [2:0] fn3, input logic [11:0] off,
                           input logic [31:0] rs1, input logic [31:0] rs2);
        rows.push_back('{st: st, fn3: fn3, off: off, rs1: rs1, rs2: rs2, id: next_id});
        next_id = next_id + 1;
    endtask

    function automatic logic [31:0] make_instr(input row_t r);
        if (r.st)
            return {r.off[11:5], 5'd3, 5'd1, r.fn3, r.off[4:0], STORE_OPCODE};
        return {r.off, 5'd1, r.fn3, 5'd2, LOAD_OPCODE};
    endfunction

    // Byte address in the reference memory after the word index wraps
    function automatic int mem_index(input logic [31:0] addr);
        return ((addr >> 2) % 256) * 4 + addr[1:0];
    endfunction

    // Reference model of one issued row
    task automatic model_row(input row_t r);
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] data;
        logic        bad;
        int          base;
        addr = r.rs1 + {{20{r.off[11]}}, r.off};
        bad  = ((r.fn3 == LS_H || r.fn3 == L_HU) && addr[0]) || (r.fn3 == LS_W && addr[1:0] != 0);
        base = mem_index({addr[31:2], 2'b00});
        if (bad) begin
            exc_exp.push_back('{due: cycle + 1, id: r.id, data: addr,
                                code: r.st ? 4'd6 : 4'd4});
        end else if (r.st) begin
            if (r.fn3 == LS_B)
                ref_mem[base + addr[1:0]] = r.rs2[7:0];
            else if (r.fn3 == LS_H)
                {ref_mem[base + addr[1:0] + 1], ref_mem[base + addr[1:0]]} = r.rs2[15:0];
            else
                {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]} = r.rs2;
        end else begin
            word = {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
            case (r.fn3)
                LS_B:    data = {{24{word[8*addr[1:0]+7]}}, word[8*addr[1:0] +: 8]};
                L_BU:    data = {24'h0, word[8*addr[1:0] +: 8]};
                LS_H:    data = {{16{word[16*addr[1]+15]}}, word[16*addr[1] +: 16]};
                L_HU:    data = {16'h0, word[16*addr[1] +: 16]};
                default: data = word;
            endcase
            wb_exp.push_back('{due: cycle + 3, id: r.id, data: data, code: 4'd0});
        end
    endtask

    task automatic build_table();
        int k;
        // Store word then load word
        add_row(1, LS_W, 12'd0, 32'h100, $random(seed));
        add_row(0, LS_W, 12'd0, 32'h100, 0);
        // Partial stores merged into a word
        add_row(1, LS_W, 12'd4, 32'h100, $random(seed));
        add_row(1, LS_B, 12'd5, 32'h100, $random(seed));
        add_row(1, LS_H, 12'd6, 32'h100, $random(seed));
        add_row(0, LS_W, 12'd4, 32'h100, 0);
        // Extension at every byte offset
        add_row(1, LS_W, 12'd8, 32'h100, 32'h8001_7FFE);
        for (k = 0; k < 4; k++) begin
            add_row(0, LS_B, 12'(8 + k), 32'h100, 0);
            add_row(0, L_BU, 12'(8 + k), 32'h100, 0);
        end
        add_row(0, LS_H, 12'd8, 32'h100, 0);
        add_row(0, LS_H, 12'd10, 32'h100, 0);
        add_row(0, L_HU, 12'd8, 32'h100, 0);
        add_row(0, L_HU, 12'd10, 32'h100, 0);
        // Negative offsets
        add_row(1, LS_W, 12'hFF8, 32'h120, $random(seed));
        add_row(0, LS_W, 12'hFFC, 32'h11C, 0);
        add_row(1, LS_W, 12'hFFC, 32'h200, $random(seed));
        add_row(1, LS_B, 12'hFFF, 32'h200, $random(seed));
        add_row(0, L_BU, 12'h00F, 32'h1F0, 0);
        // Large offset wrapping onto the last RAM word
        add_row(1, LS_W, 12'd0, 32'h3FC, $random(seed));
        add_row(0, LS_W, 12'h7F0, 32'h1FFFF80C, 0);
        // Misaligned accesses leave memory unchanged
        add_row(0, LS_H, 12'd1, 32'h100, 0);
        add_row(0, LS_W, 12'd2, 32'h100, 0);
        add_row(1, LS_H, 12'd3, 32'h100, $random(seed));
        add_row(1, LS_W, 12'd1, 32'h100, $random(seed));
        add_row(0, L_HU, 12'hFFF, 32'h108, 0);
        add_row(0, LS_W, 12'd0, 32'h100, 0);
        add_row(0, LS_W, 12'd4, 32'h100, 0);
    endtask

    // Outputs compared in the middle of the cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (wb_exp.size() > 0 && wb_exp[0].due == cycle) begin
                check("wb_valid", wb_valid, 1);
                check("wb id", wb.id, wb_exp[0].id);
                check("wb data", wb.data, wb_exp[0].data);
                void'(wb_exp.pop_front());
            end else begin
                check("unexpected wb_valid", wb_valid, 0);
            end
            if (exc_exp.size() > 0 && exc_exp[0].due == cycle) begin
                check("exc_valid", exc_valid, 1);
                check("exc code", exc.code, exc_exp[0].code);
                check("exc tval", exc.tval, exc_exp[0].data);
                check("exc id", exc.id, exc_exp[0].id);
                void'(exc_exp.pop_front());
            end else begin
                check("unexpected exc_valid", exc_valid, 0);
            end
        end
    end

    initial begin
        issue_valid = 1'b0;
        issue       = '0;
        next_id     = 4'd1;
        seed        = 43088;
        error_count = 0;
        build_table();

        fork
            begin
                #((rows.size() + 8 + 20) * 10);
                $display("Timeout: the run did not finish in time");
                $display("Checks failed");
                $fatal(1, "watchdog expired");
            end
        join_none

        @(negedge rst);

        // One row per cycle back to back
        foreach (rows[i]) begin
            @(posedge clk);
            #1;
            issue_valid = 1'b1;
            issue = '{instr: make_instr(rows[i]), rs1: rows[i].rs1,
                      rs2: rows[i].rs2, id: rows[i].id};
            model_row(rows[i]);
        end
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
        issue       = '0;

        while (wb_exp.size() > 0 || exc_exp.size() > 0)
            @(negedge clk);
        @(negedge clk);
        check("idle", idle, 1);

        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
// Testbench clock and synchronous reset generator
`default_nettype none

module tb_clock_gen #(
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for a fixed number of rising edges
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire
